// ==== include/snd_settings.svh ====
`ifndef SND_SETTINGS_SVH
`define SND_SETTINGS_SVH

// 640x480 at 60 Hz with a 25 MHz pixel clock

// horizontal timing in pixels
`define SND_H_VISIBLE     640
`define SND_H_SYNC_START  656   // front porch of 16 pixels
`define SND_H_SYNC_END    752   // sync pulse of 96 pixels
`define SND_H_TOTAL       800   // back porch fills the rest

// vertical timing in lines
`define SND_V_VISIBLE     480
`define SND_V_SYNC_START  490   // front porch of 10 lines
`define SND_V_SYNC_END    492   // sync pulse of 2 lines
`define SND_V_TOTAL       525

// snare window length in scanlines
// 6000 lines is roughly 190 ms at 31.5 kHz line rate
`define SND_SNARE_LINES   6000

// scanlines per noise update
`define SND_NOISE_DIV     3     // sets the noise pitch

// frame counter step per frame
`define SND_FRAME_STEP    1     // music speed for 60 fps

`endif

// ==== hdl/snd_pkg.sv ====
package snd_pkg;

  // coordinate width
  // 10 bits cover 800 columns and 525 lines
  localparam int unsigned COORD_W = 10;

  typedef logic [COORD_W-1:0] coord_t;

  // current scan position
  // x is the pixel column and y the scanline
  typedef struct packed {
    coord_t x;      // column 0..799
    coord_t y;      // line 0..524
  } scan_pos_t;

  // sync levels that go with one scan position
  // all active high
  typedef struct packed {
    logic hsync;      // x in the horizontal sync pulse
    logic vsync;      // y in the vertical sync pulse
    logic display_on; // inside the visible 640x480 area
  } video_sync_t;

endpackage

// ==== hdl/vga_timing.sv ====
`include "snd_settings.svh"

module vga_timing (
  input  logic                 clk,
  input  logic                 reset,
  output snd_pkg::scan_pos_t   pos,
  output snd_pkg::video_sync_t sync
);

  // timing constants in counter width
  localparam snd_pkg::coord_t H_VISIBLE    = snd_pkg::coord_t'(`SND_H_VISIBLE);
  localparam snd_pkg::coord_t H_SYNC_START = snd_pkg::coord_t'(`SND_H_SYNC_START);
  localparam snd_pkg::coord_t H_SYNC_END   = snd_pkg::coord_t'(`SND_H_SYNC_END);
  localparam snd_pkg::coord_t H_LAST       = snd_pkg::coord_t'(`SND_H_TOTAL - 1);
  localparam snd_pkg::coord_t V_VISIBLE    = snd_pkg::coord_t'(`SND_V_VISIBLE);
  localparam snd_pkg::coord_t V_SYNC_START = snd_pkg::coord_t'(`SND_V_SYNC_START);
  localparam snd_pkg::coord_t V_SYNC_END   = snd_pkg::coord_t'(`SND_V_SYNC_END);
  localparam snd_pkg::coord_t V_LAST       = snd_pkg::coord_t'(`SND_V_TOTAL - 1);

  snd_pkg::scan_pos_t   pos_next;   // position for the next cycle
  snd_pkg::video_sync_t sync_next;  // decode of pos_next
  logic                 h_wrap;     // last column of the line
  logic                 v_wrap;     // last line of the frame

  // counter step
  // x runs every clock and y runs when x wraps
  always_comb begin
    h_wrap   = (pos.x == H_LAST);
    v_wrap   = (pos.y == V_LAST);
    pos_next = pos;
    if (h_wrap) begin
      pos_next.x = '0;
      if (v_wrap) begin
        pos_next.y = '0;          // back to the top of the frame
      end else begin
        pos_next.y = pos.y + snd_pkg::coord_t'(1);
      end
    end else begin
      pos_next.x = pos.x + snd_pkg::coord_t'(1);
    end
  end

  // sync decode from the next position
  // registered together with pos so both line up in the same cycle
  always_comb begin
    sync_next.hsync      = (pos_next.x >= H_SYNC_START) && (pos_next.x < H_SYNC_END);
    sync_next.vsync      = (pos_next.y >= V_SYNC_START) && (pos_next.y < V_SYNC_END);
    sync_next.display_on = (pos_next.x < H_VISIBLE) && (pos_next.y < V_VISIBLE);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pos              <= '0;     // scan restarts at 0/0
      sync.hsync       <= 1'b0;
      sync.vsync       <= 1'b0;
      sync.display_on  <= 1'b1;   // 0/0 lies in the visible area
    end else begin
      pos  <= pos_next;
      sync <= sync_next;
    end
  end

  // counters never leave the frame
  a_x_range: assert property (
    @(posedge clk) disable iff (reset)
    pos.x <= H_LAST
  ) else $error("vga_timing: x out of range %0d", pos.x);

  a_y_range: assert property (
    @(posedge clk) disable iff (reset)
    pos.y <= V_LAST
  ) else $error("vga_timing: y out of range %0d", pos.y);

  // y only moves on the cycle after the last column
  a_y_step: assert property (
    @(posedge clk) disable iff (reset)
    $changed(pos.y) |-> $past(pos.x) == H_LAST
  ) else $error("vga_timing: y changed without x wrap");

endmodule

// ==== hdl/snare_apu.sv ====
`include "snd_settings.svh"

module snare_apu (
  input  logic               clk,
  input  logic               reset,
  input  logic               snare_trigger,   // level input whose rising edge starts the snare
  input  snd_pkg::scan_pos_t pos,
  output logic               sound            // pulse density output
);

  // counter widths follow the timing defines
  localparam int unsigned LINE_W = $clog2(`SND_SNARE_LINES + 1);
  localparam int unsigned NDIV_W = $clog2(`SND_NOISE_DIV + 1);

  localparam logic [LINE_W-1:0] LINE_LAST  = LINE_W'(`SND_SNARE_LINES);
  localparam logic [NDIV_W-1:0] NDIV_LAST  = NDIV_W'(`SND_NOISE_DIV - 1);
  localparam logic [3:0]        FRAME_STEP = 4'(`SND_FRAME_STEP);
  localparam logic [4:0]        ENV_TOP    = 5'd31;   // envelope at frame 0

  logic [12:0]       lfsr;          // noise source
  logic              lfsr_fb;
  logic              line_start;    // first column of any line
  logic              frame_start;   // first column of line 0
  logic [NDIV_W-1:0] noise_cnt;     // lines since last noise update
  logic              noise;         // current noise bit
  logic [3:0]        frame_cnt;     // drives the envelope
  logic [4:0]        env_level;
  snd_pkg::coord_t   env_bound;     // envelope in pixels
  logic              trig_q;        // trigger one cycle late
  logic              snare_start;   // one cycle pulse on trigger edge
  logic              snare_active;  // snare window
  logic [LINE_W-1:0] line_cnt;      // lines since window opened

  assign line_start  = (pos.x == '0);
  assign frame_start = line_start && (pos.y == '0);

  // 13 bit lfsr
  // xnor feedback keeps the all-zero state inside the sequence
  assign lfsr_fb = ~(lfsr[12] ^ lfsr[8] ^ lfsr[2] ^ lfsr[0]);

  always_ff @(posedge clk) begin
    if (reset) begin
      lfsr <= '0;
    end else begin
      lfsr <= {lfsr[11:0], lfsr_fb};   // steps every clock
    end
  end

  // noise bit
  // every third line start it toggles with the lfsr parity
  always_ff @(posedge clk) begin
    if (reset) begin
      noise_cnt <= '0;
      noise     <= 1'b0;
    end else if (line_start) begin
      if (noise_cnt >= NDIV_LAST) begin
        noise_cnt <= '0;
        noise     <= noise ^ (^lfsr);
      end else begin
        noise_cnt <= noise_cnt + NDIV_W'(1);
      end
    end
  end

  // frame counter wraps after 16 frames
  always_ff @(posedge clk) begin
    if (reset) begin
      frame_cnt <= '0;
    end else if (frame_start) begin
      frame_cnt <= frame_cnt + FRAME_STEP;
    end
  end

  // decaying envelope
  // 31 - 2*frame lands on 1 at frame 15 so the bound bottoms at 4 pixels
  assign env_level = ENV_TOP - {frame_cnt, 1'b0};
  assign env_bound = {3'b000, env_level, 2'b00};   // times 4 in pixels

  // trigger edge detect
  always_ff @(posedge clk) begin
    if (reset) begin
      trig_q      <= 1'b0;
      snare_start <= 1'b0;
    end else begin
      trig_q      <= snare_trigger;
      snare_start <= snare_trigger & ~trig_q;   // high for one cycle per edge
    end
  end

  // snare window
  // a start pulse (re)opens it and clears the line count
  // the line start that finds the count at the limit closes it
  always_ff @(posedge clk) begin
    if (reset) begin
      snare_active <= 1'b0;
      line_cnt     <= '0;
    end else if (snare_start) begin
      snare_active <= 1'b1;
      line_cnt     <= '0;
    end else if (snare_active && line_start) begin
      line_cnt <= line_cnt + LINE_W'(1);
      if (line_cnt >= LINE_LAST) begin
        snare_active <= 1'b0;   // 6001st line start of the window
      end
    end
  end

  // noise gated by window and envelope with no register
  assign sound = snare_active & noise & (pos.x < env_bound);

  // window only closes on a line boundary
  a_close_at_line: assert property (
    @(posedge clk) disable iff (reset)
    $fell(snare_active) |-> $past(line_start)
  ) else $error("snare_apu: window closed off a line start");

  a_start_single: assert property (
    @(posedge clk) disable iff (reset)
    snare_start |=> !snare_start
  ) else $error("snare_apu: start pulse longer than one cycle");

endmodule

// ==== hdl/snd_top.sv ====
module snd_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 snare_trigger,  // button level from outside
  output snd_pkg::video_sync_t sync,           // to the VGA connector
  output snd_pkg::scan_pos_t   pos,            // for an outside pixel generator
  output logic                 sound           // one bit audio stream
);

  // scan position shared by the audio unit and the outside
  snd_pkg::scan_pos_t scan_pos;

  // frame scan and sync
  vga_timing u_timing (
    .clk   (clk),
    .reset (reset),
    .pos   (scan_pos),
    .sync  (sync)
  );

  // snare voice follows the scan with no extra delay
  snare_apu u_apu (
    .clk           (clk),
    .reset         (reset),
    .snare_trigger (snare_trigger),
    .pos           (scan_pos),
    .sound         (sound)
  );

  assign pos = scan_pos;   // same cycle as sync and sound

endmodule

// ==== tb/snd_tb.sv ====
`include "snd_settings.svh"

module snd_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // frame geometry in clock cycles
  localparam int H_TOTAL      = `SND_H_TOTAL;
  localparam int V_TOTAL      = `SND_V_TOTAL;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;   // 420000 cycles per frame

  // window length in line starts with the last count included
  localparam int WINDOW_STARTS = `SND_SNARE_LINES + 1;
  localparam int TAIL_LINES    = 400;   // end part of the window that the retrigger moves

  // run is about 16 frames and the watchdog allows 18
  localparam int     WATCHDOG_FRAMES = 18;
  localparam longint WATCHDOG_NS     = longint'(WATCHDOG_FRAMES) * FRAME_CYCLES * 8;

  // timing constants in coordinate width
  localparam snd_pkg::coord_t X_LAST       = snd_pkg::coord_t'(`SND_H_TOTAL - 1);
  localparam snd_pkg::coord_t Y_LAST       = snd_pkg::coord_t'(`SND_V_TOTAL - 1);
  localparam snd_pkg::coord_t H_VISIBLE    = snd_pkg::coord_t'(`SND_H_VISIBLE);
  localparam snd_pkg::coord_t H_SYNC_START = snd_pkg::coord_t'(`SND_H_SYNC_START);
  localparam snd_pkg::coord_t H_SYNC_END   = snd_pkg::coord_t'(`SND_H_SYNC_END);
  localparam snd_pkg::coord_t V_VISIBLE    = snd_pkg::coord_t'(`SND_V_VISIBLE);
  localparam snd_pkg::coord_t V_SYNC_START = snd_pkg::coord_t'(`SND_V_SYNC_START);
  localparam snd_pkg::coord_t V_SYNC_END   = snd_pkg::coord_t'(`SND_V_SYNC_END);

  logic                 clk;
  logic                 reset;
  logic                 snare_trigger;
  snd_pkg::video_sync_t sync;
  snd_pkg::scan_pos_t   pos;
  logic                 sound;

  // reference models
  snd_pkg::scan_pos_t exp_pos;          // expected scan position
  logic               rst_seen = 1'b0;  // one reset edge has passed
  logic               trig_seen;        // trigger high since reset
  logic               line_start_m;     // pos at column 0
  logic               hsync_m;
  logic               vsync_m;
  logic               display_m;
  logic [3:0]         frame_m;          // frame counter model
  int                 bound_m;          // envelope bound in pixels
  logic               trig_q_m;         // trigger one cycle late
  logic               start_m;          // expected start pulse
  logic               win_m;            // expected snare window
  logic               win_d;            // window one cycle late
  int                 left_m;           // line starts left in the window
  logic               heard;            // sound seen in this window
  logic               heard_tail;       // sound seen near the window end
  int                 closes_seen;
  logic               low_bound_seen;   // sound seen at the 4 pixel bound

  snd_top dut (
    .clk           (clk),
    .reset         (reset),
    .snare_trigger (snare_trigger),
    .sync          (sync),
    .pos           (pos),
    .sound         (sound)
  );

  initial begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;   // 8 ns period

  // first error ends the run
  task automatic stop_on_error();
    $display("TB FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  // whole lines of clock cycles
  task automatic wait_lines(input int unsigned n);
    repeat (n * H_TOTAL) @(posedge clk);
  endtask

  // trigger level held high for a number of cycles
  task automatic hold_trigger(input int unsigned cycles);
    @(posedge clk);
    snare_trigger <= 1'b1;
    repeat (cycles) @(posedge clk);
    snare_trigger <= 1'b0;   // back low well inside one line
  endtask

  // expected scan steps x every clock and y when x wraps
  always @(posedge clk) begin
    if (reset) begin
      exp_pos <= '0;
    end else if (exp_pos.x == X_LAST) begin
      exp_pos.x <= '0;
      exp_pos.y <= (exp_pos.y == Y_LAST) ? '0 : exp_pos.y + snd_pkg::coord_t'(1);
    end else begin
      exp_pos.x <= exp_pos.x + snd_pkg::coord_t'(1);
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      rst_seen <= 1'b1;
    end
  end

  // sync decode of the current position
  always_comb begin
    line_start_m = (pos.x == '0);
    hsync_m      = (pos.x >= H_SYNC_START) && (pos.x < H_SYNC_END);
    vsync_m      = (pos.y >= V_SYNC_START) && (pos.y < V_SYNC_END);
    display_m    = (pos.x < H_VISIBLE) && (pos.y < V_VISIBLE);
  end

  // envelope bound is 4 * (31 - 2 * frame)
  always_comb begin
    bound_m = 4 * (31 - 2 * int'(frame_m));
  end

  // frame counter stepped on frame starts seen on pos
  always @(posedge clk) begin
    if (reset) begin
      frame_m        <= '0;
      low_bound_seen <= 1'b0;
      trig_seen      <= 1'b0;
    end else begin
      if (line_start_m && pos.y == '0) begin
        frame_m <= frame_m + 4'(`SND_FRAME_STEP);
      end
      if (bound_m == 4 && sound) begin
        low_bound_seen <= 1'b1;   // envelope check reached at its narrowest
      end
      if (snare_trigger) begin
        trig_seen <= 1'b1;
      end
    end
  end

  // expected snare window
  // opens 2 cycles after a rising trigger edge and lasts 6001 line starts
  always @(posedge clk) begin
    if (reset) begin
      trig_q_m    <= 1'b0;
      start_m     <= 1'b0;
      win_m       <= 1'b0;
      win_d       <= 1'b0;
      left_m      <= 0;
      heard       <= 1'b0;
      heard_tail  <= 1'b0;
      closes_seen <= 0;
    end else begin
      trig_q_m <= snare_trigger;
      start_m  <= snare_trigger && !trig_q_m;   // rising edge on the input
      win_d    <= win_m;
      if (win_m && sound) begin
        heard <= 1'b1;
        if (left_m <= TAIL_LINES) begin
          heard_tail <= 1'b1;
        end
      end
      if (start_m) begin
        // a retrigger starts over with a full window
        win_m      <= 1'b1;
        left_m     <= WINDOW_STARTS;
        heard      <= 1'b0;
        heard_tail <= 1'b0;
      end else if (win_m && line_start_m) begin
        left_m <= left_m - 1;
        if (left_m == 1) begin
          win_m       <= 1'b0;   // last line start of the window
          closes_seen <= closes_seen + 1;
        end
      end
    end
  end

  // reset keeps the outputs quiet and the scan at 0/0
  a_reset_sound: assert property (@(posedge clk) rst_seen && reset |-> !sound)
    else begin
      $display("Mismatch at %0t: sound expected 0 got %b", $time, $sampled(sound));
      stop_on_error();
    end

  a_reset_pos: assert property (@(posedge clk) rst_seen && reset |-> pos == '0)
    else begin
      $display("Mismatch at %0t: pos expected 0/0 got %0d/%0d", $time,
               $sampled(pos.x), $sampled(pos.y));
      stop_on_error();
    end

  // scan steps with periods of 800 and 525
  a_pos_x: assert property (@(posedge clk) !reset |-> pos.x == exp_pos.x)
    else begin
      $display("Mismatch at %0t: pos.x expected %0d got %0d", $time,
               $sampled(exp_pos.x), $sampled(pos.x));
      stop_on_error();
    end

  a_pos_y: assert property (@(posedge clk) !reset |-> pos.y == exp_pos.y)
    else begin
      $display("Mismatch at %0t: pos.y expected %0d got %0d", $time,
               $sampled(exp_pos.y), $sampled(pos.y));
      stop_on_error();
    end

  // sync levels line up with pos in the same cycle
  a_hsync: assert property (@(posedge clk) rst_seen |-> sync.hsync == hsync_m)
    else begin
      $display("Mismatch at %0t: hsync expected %b got %b", $time,
               $sampled(hsync_m), $sampled(sync.hsync));
      stop_on_error();
    end

  a_vsync: assert property (@(posedge clk) rst_seen |-> sync.vsync == vsync_m)
    else begin
      $display("Mismatch at %0t: vsync expected %b got %b", $time,
               $sampled(vsync_m), $sampled(sync.vsync));
      stop_on_error();
    end

  a_display: assert property (@(posedge clk) rst_seen |-> sync.display_on == display_m)
    else begin
      $display("Mismatch at %0t: display_on expected %b got %b", $time,
               $sampled(display_m), $sampled(sync.display_on));
      stop_on_error();
    end

  // silence until the first trigger
  a_quiet: assert property (@(posedge clk) rst_seen && !trig_seen |-> !sound)
    else begin
      $display("Mismatch at %0t: sound expected 0 got 1 before any trigger", $time);
      stop_on_error();
    end

  a_window: assert property (@(posedge clk) rst_seen && sound |-> win_m)
    else begin
      $display("Mismatch at %0t: sound expected 0 got 1 outside the snare window", $time);
      stop_on_error();
    end

  a_envelope: assert property (@(posedge clk) rst_seen && sound |-> int'(pos.x) < bound_m)
    else begin
      $display("Mismatch at %0t: sound expected 0 got 1 at x %0d with bound %0d", $time,
               $sampled(pos.x), $sampled(bound_m));
      stop_on_error();
    end

  // noise path liveness checked on the cycle after the window closes
  a_heard: assert property (@(posedge clk) win_d && !win_m |-> heard)
    else begin
      $display("sound never went high inside the snare window");
      stop_on_error();
    end

  // a missed restart would close the window before this tail
  a_heard_tail: assert property (@(posedge clk) win_d && !win_m |-> heard_tail)
    else begin
      $display("no sound near the end of the restarted snare window");
      stop_on_error();
    end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: simulation did not finish within %0d frames", WATCHDOG_FRAMES);
    stop_on_error();
  end

  // stimulus
  initial begin
    void'($urandom(32'h7423));
    reset         = 1'b1;
    snare_trigger = 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    wait_lines(630);                              // about 1.2 frames with no trigger
    wait_lines(1 + $urandom_range(0, 200));       // random trigger line
    hold_trigger(1 + $urandom_range(0, 399));
    // retrigger inside the window, late enough that it still runs in frame 15
    wait_lines(850 + $urandom_range(0, 150));
    hold_trigger(1 + $urandom_range(0, 399));

    while (closes_seen == 0) begin
      @(posedge clk);
    end
    // run on into frame 15 where the bound is 4 pixels and then past the wrap
    while (frame_m != 4'd15) begin
      @(posedge clk);
    end
    while (frame_m != 4'd0) begin
      @(posedge clk);
    end
    wait_lines(4);

    if (low_bound_seen) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("no sound was seen while the envelope bound was 4 pixels");
      stop_on_error();
    end
  end

endmodule

// ==== files.f ====
+incdir+include
hdl/snd_pkg.sv
hdl/vga_timing.sv
hdl/snare_apu.sv
hdl/snd_top.sv
tb/snd_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module snd_tb -f files.f -o snd_sim || exit 1
out=$(./obj_dir/snd_sim 2>&1)
echo "$out"
echo "$out" | grep -q "TB PASSED" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
